// ==== src/apb_if.sv ====
`timescale 1ns/1ps

interface apb_if;

	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	modport master (
		output psel,
		output penable,
		output pwrite,
		output paddr,
		output pwdata,
		input  prdata,
		input  pready,
		input  pslverr
	);

	modport slave (
		input  psel,
		input  penable,
		input  pwrite,
		input  paddr,
		input  pwdata,
		output prdata,
		output pready,
		output pslverr
	);

endinterface

// ==== src/status_apb_regs.sv ====
`timescale 1ns/1ps

module status_apb_regs #(
	parameter int CNT_WIDTH = 16
) (
	apb_if.slave                   apb,
	input  logic                   CLK,
	input  logic                   MODULE_RST,
	input  logic                   remote_reset,
	input  logic                   fifo_full,
	input  logic                   training_done,
	input  logic                   link_idle,
	input  logic                   idle_entry,
	input  logic                   status_error,
	output status_pkg::link_cond_e tx_cond,
	output logic                   tx_enable
);

	import status_pkg::*;

	logic                 access;
	logic                 addr_ok;
	logic                 wr_ctrl;
	logic                 wr_cnt;
	logic [31:0]          status_word;
	logic [CNT_WIDTH-1:0] idle_cnt;

	assign access  = apb.psel && apb.penable;
	assign addr_ok = (apb.paddr == REG_CTRL) || (apb.paddr == REG_STATUS) ||
		(apb.paddr == REG_IDLE_CNT);
	assign wr_ctrl = access && apb.pwrite && (apb.paddr == REG_CTRL);
	assign wr_cnt  = access && apb.pwrite && (apb.paddr == REG_IDLE_CNT);

	always_comb begin
		status_word                     = 32'd0;
		status_word[STAT_REMOTE_RESET]  = remote_reset;
		status_word[STAT_FIFO_FULL]     = fifo_full;
		status_word[STAT_TRAINING_DONE] = training_done;
		status_word[STAT_STATUS_ERROR]  = status_error;
		status_word[STAT_LINK_IDLE]     = link_idle;
	end

	always_ff @(posedge CLK) begin
		if (MODULE_RST) begin
			tx_cond   <= COND_RST;
			tx_enable <= 1'b0;
		end else if (wr_ctrl) begin
			tx_cond   <= link_cond_e'(apb.pwdata[CTRL_COND_LSB +: 2]);
			tx_enable <= apb.pwdata[CTRL_EN_BIT];
		end
	end

	// clear has priority over a pulse in the same cycle.
	always_ff @(posedge CLK) begin
		if (MODULE_RST) begin
			idle_cnt <= '0;
		end else if (wr_cnt) begin
			idle_cnt <= '0;
		end else if (idle_entry && (idle_cnt != '1)) begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	// read data is combinational, valid in the access cycle.
	always_comb begin
		case (apb.paddr)
			REG_CTRL: begin
				apb.prdata                           = 32'd0;
				apb.prdata[CTRL_COND_LSB +: 2]       = tx_cond;
				apb.prdata[CTRL_EN_BIT]              = tx_enable;
			end
			REG_STATUS:   apb.prdata = status_word;
			REG_IDLE_CNT: apb.prdata = 32'(idle_cnt);
			default:      apb.prdata = 32'd0;
		endcase
	end

	assign apb.pready  = 1'b1;
	assign apb.pslverr = access && !addr_ok;

	a_penable_psel: assert property (@(posedge CLK) disable iff (MODULE_RST)
		apb.penable |-> apb.psel);

	// access phase always follows a setup phase.
	a_setup_first: assert property (@(posedge CLK) disable iff (MODULE_RST)
		(apb.psel && !apb.penable) |=> (apb.psel && apb.penable));

endmodule

// ==== src/status_decoder.sv ====
`timescale 1ns/1ps

module status_decoder #(
	parameter int ERR_LIMIT = 12
) (
	input  logic                   CLK,
	input  logic                   MODULE_RST,
	input  logic                   status_in,
	output status_pkg::link_cond_e cond,
	output logic                   cond_valid,
	output logic                   status_error
);

	import status_pkg::*;

	localparam int CNT_W = $clog2(ERR_LIMIT + 1);

	logic [7:0]       window;
	link_cond_e       win_cond;
	logic             win_valid;
	logic [CNT_W-1:0] amb_cnt;

	// true when w is any rotation of code.
	function automatic logic is_rotation(input logic [7:0] w, input logic [7:0] code);
		logic [7:0] rot;
		logic       hit;
		int         i;
		rot = code;
		hit = 1'b0;
		for (i = 0; i < 8; i++) begin
			if (w == rot) begin
				hit = 1'b1;
			end
			rot = {rot[6:0], rot[7]};
		end
		return hit;
	endfunction

	always_ff @(posedge CLK) begin
		if (MODULE_RST) begin
			window <= 8'h00;
		end else begin
			window <= {window[6:0], status_in};
		end
	end

	always_comb begin
		win_valid = 1'b1;
		win_cond  = COND_IDLE;
		if (is_rotation(window, CODE_RST)) begin
			win_cond = COND_RST;
		end else if (is_rotation(window, CODE_FULL)) begin
			win_cond = COND_FULL;
		end else if (is_rotation(window, CODE_DONE)) begin
			win_cond = COND_DONE;
		end else if (is_rotation(window, CODE_IDLE)) begin
			win_cond = COND_IDLE;
		end else begin
			win_valid = 1'b0;
		end
	end

	// cond keeps the last good value through ambiguous windows.
	always_ff @(posedge CLK) begin
		if (MODULE_RST) begin
			cond       <= COND_IDLE;
			cond_valid <= 1'b0;
		end else begin
			cond_valid <= win_valid;
			if (win_valid) begin
				cond <= win_cond;
			end
		end
	end

	// run length of ambiguous windows, saturating at the limit.
	always_ff @(posedge CLK) begin
		if (MODULE_RST) begin
			amb_cnt <= '0;
		end else if (win_valid) begin
			amb_cnt <= '0;
		end else if (amb_cnt != CNT_W'(ERR_LIMIT)) begin
			amb_cnt <= amb_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (MODULE_RST) begin
			status_error <= 1'b0;
		end else begin
			status_error <= (amb_cnt == CNT_W'(ERR_LIMIT));
		end
	end

	a_err_after_invalid: assert property (@(posedge CLK) disable iff (MODULE_RST)
		status_error |-> !$past(cond_valid));

endmodule

// ==== src/status_flags.sv ====
`timescale 1ns/1ps

module status_flags (
	input  logic                   CLK,
	input  logic                   MODULE_RST,
	input  status_pkg::link_cond_e cond,
	input  logic                   cond_valid,
	output logic                   remote_reset,
	output logic                   fifo_full,
	output logic                   training_done,
	output logic                   link_idle,
	output logic                   idle_entry
);

	import status_pkg::*;

	// set once idle has been reported, cleared by any other condition.
	logic idle_seen;

	always_ff @(posedge CLK) begin
		if (MODULE_RST) begin
			remote_reset  <= 1'b0;
			fifo_full     <= 1'b0;
			training_done <= 1'b0;
			link_idle     <= 1'b0;
			idle_entry    <= 1'b0;
			idle_seen     <= 1'b0;
		end else begin
			idle_entry <= 1'b0;
			if (cond_valid) begin
				remote_reset  <= (cond == COND_RST);
				fifo_full     <= (cond == COND_FULL);
				training_done <= (cond == COND_FULL) || (cond == COND_DONE);
				link_idle     <= (cond == COND_IDLE);
				if (cond == COND_IDLE) begin
					idle_entry <= !idle_seen;
					idle_seen  <= 1'b1;
				end else begin
					idle_seen <= 1'b0;
				end
			end
		end
	end

	a_rst_vs_done: assert property (@(posedge CLK) disable iff (MODULE_RST)
		!(remote_reset && training_done));

endmodule

// ==== src/status_link.sv ====
`timescale 1ns/1ps

module status_link #(
	parameter int ERR_LIMIT = 12,
	parameter int CNT_WIDTH = 16
) (
	input  logic        CLK,
	input  logic        MODULE_RST,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic        status_in,
	output logic        status_out
);

	import status_pkg::*;

	link_cond_e tx_cond;
	logic       tx_enable;
	link_cond_e cond;
	logic       cond_valid;
	logic       status_error;
	logic       remote_reset;
	logic       fifo_full;
	logic       training_done;
	logic       link_idle;
	logic       idle_entry;

	apb_if apb_bus ();

	// request side of the bus comes from the top ports.
	assign apb_bus.psel    = psel;
	assign apb_bus.penable = penable;
	assign apb_bus.pwrite  = pwrite;
	assign apb_bus.paddr   = paddr;
	assign apb_bus.pwdata  = pwdata;
	assign prdata          = apb_bus.prdata;
	assign pready          = apb_bus.pready;
	assign pslverr         = apb_bus.pslverr;

	status_apb_regs #(.CNT_WIDTH(CNT_WIDTH)) regs_i (
		.apb(apb_bus.slave), .CLK(CLK), .MODULE_RST(MODULE_RST),
		.remote_reset(remote_reset), .fifo_full(fifo_full),
		.training_done(training_done), .link_idle(link_idle),
		.idle_entry(idle_entry), .status_error(status_error),
		.tx_cond(tx_cond), .tx_enable(tx_enable)
	);

	status_serializer ser_i (
		.CLK(CLK), .MODULE_RST(MODULE_RST), .tx_cond(tx_cond),
		.tx_enable(tx_enable), .status_out(status_out)
	);

	status_decoder #(.ERR_LIMIT(ERR_LIMIT)) dec_i (
		.CLK(CLK), .MODULE_RST(MODULE_RST), .status_in(status_in),
		.cond(cond), .cond_valid(cond_valid), .status_error(status_error)
	);

	status_flags flags_i (
		.CLK(CLK), .MODULE_RST(MODULE_RST), .cond(cond), .cond_valid(cond_valid),
		.remote_reset(remote_reset), .fifo_full(fifo_full),
		.training_done(training_done), .link_idle(link_idle), .idle_entry(idle_entry)
	);

endmodule

// ==== src/status_pkg.sv ====
package status_pkg;

	// link condition carried on the status line.
	typedef enum logic [1:0] {
		COND_RST  = 2'd0,
		COND_FULL = 2'd1,
		COND_DONE = 2'd2,
		COND_IDLE = 2'd3
	} link_cond_e;

	// base codes, every rotation of a code means the same condition.
	localparam logic [7:0] CODE_RST  = 8'h55;
	localparam logic [7:0] CODE_FULL = 8'hF0;
	localparam logic [7:0] CODE_DONE = 8'h33;
	localparam logic [7:0] CODE_IDLE = 8'h00;

	// apb word addresses.
	localparam logic [7:0] REG_CTRL     = 8'h00;
	localparam logic [7:0] REG_STATUS   = 8'h04;
	localparam logic [7:0] REG_IDLE_CNT = 8'h08;

	// control register fields.
	localparam int CTRL_COND_LSB = 0;
	localparam int CTRL_EN_BIT   = 2;

	// status register bit positions.
	localparam int STAT_REMOTE_RESET  = 0;
	localparam int STAT_FIFO_FULL     = 1;
	localparam int STAT_TRAINING_DONE = 2;
	localparam int STAT_STATUS_ERROR  = 3;
	localparam int STAT_LINK_IDLE     = 4;

endpackage

// ==== src/status_serializer.sv ====
`timescale 1ns/1ps

module status_serializer (
	input  logic                   CLK,
	input  logic                   MODULE_RST,
	input  status_pkg::link_cond_e tx_cond,
	input  logic                   tx_enable,
	output logic                   status_out
);

	import status_pkg::*;

	logic [7:0] code_reg;
	logic [2:0] bit_cnt;
	logic [7:0] next_code;

	// code picked up at the next code boundary.
	always_comb begin
		if (!tx_enable) begin
			next_code = CODE_IDLE;
		end else begin
			case (tx_cond)
				COND_RST:  next_code = CODE_RST;
				COND_FULL: next_code = CODE_FULL;
				COND_DONE: next_code = CODE_DONE;
				default:   next_code = CODE_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (MODULE_RST) begin
			code_reg <= CODE_IDLE;
			bit_cnt  <= 3'd0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				code_reg <= next_code;
			end else begin
				code_reg <= {code_reg[6:0], code_reg[7]};
			end
		end
	end

	// msb first, the line always shows the top bit.
	assign status_out = code_reg[7];

	a_bit_cnt_wrap: assert property (@(posedge CLK) disable iff (MODULE_RST)
		(bit_cnt != 3'd7) |=> (bit_cnt != 3'd0));

endmodule

// ==== status_link.f ====
src/status_pkg.sv
src/apb_if.sv
src/status_serializer.sv
src/status_decoder.sv
src/status_flags.sv
src/status_apb_regs.sv
src/status_link.sv
verif/status_link_tb.sv

// ==== verif/status_link_tb.sv ====
`timescale 1ns/1ps

module status_link_tb;

	import status_pkg::*;

	logic        CLK;
	logic        MODULE_RST;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        status_in;
	logic        status_out;

	// line source, either the transmit line or a byte pattern.
	logic        loopback;
	logic [7:0]  drv_pattern;
	logic [7:0]  drv_shift;
	logic [2:0]  drv_cnt;

	int          errors;
	int          checks;
	int          tests_run;
	int          exp_idle_cnt;
	logic [1:0]  last_cond;

	status_link dut_i (
		.CLK(CLK), .MODULE_RST(MODULE_RST), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .status_in(status_in),
		.status_out(status_out)
	);

	always #5 CLK = ~CLK;

	// new patterns are taken only at a byte boundary.
	always @(posedge CLK) begin
		#1;
		if (drv_cnt == 3'd0) begin
			drv_shift = drv_pattern;
		end
		if (loopback) begin
			status_in = status_out;
		end else begin
			status_in = drv_shift[7];
		end
		drv_shift = {drv_shift[6:0], drv_shift[7]};
		drv_cnt   = drv_cnt + 3'd1;
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic apb_access(input logic wr, input logic [7:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(posedge CLK);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(posedge CLK);
		#1;
		penable = 1'b1;
		@(negedge CLK);
		while (!pready && waits < 16) begin
			@(negedge CLK);
			waits++;
		end
		if (!pready) begin
			errors++;
			$display("APB access to address 0x%02h never saw pready", addr);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge CLK);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		apb_access(1'b0, addr, 32'd0, data, err);
	endtask

	// flag word expected in REG_STATUS for each condition.
	function automatic logic [31:0] flags_for(input logic [1:0] c);
		case (c)
			COND_RST:  return 32'h01;
			COND_FULL: return 32'h06;
			COND_DONE: return 32'h04;
			default:   return 32'h10;
		endcase
	endfunction

	function automatic logic [7:0] code_for(input logic [1:0] c);
		case (c)
			COND_RST:  return 8'h55;
			COND_FULL: return 8'hF0;
			COND_DONE: return 8'h33;
			default:   return 8'h00;
		endcase
	endfunction

	function automatic logic [7:0] rotate_left(input logic [7:0] b, input int n);
		logic [7:0] r;
		r = b;
		for (int i = 0; i < n; i++) begin
			r = {r[6:0], r[7]};
		end
		return r;
	endfunction

	// model of the idle-entry counter.
	task automatic note_cond(input logic [1:0] c);
		if (c == COND_IDLE && last_cond != COND_IDLE) begin
			exp_idle_cnt++;
		end
		last_cond = c;
	endtask

	task automatic wait_flags(input logic [31:0] exp, input string what);
		logic [31:0] rd;
		logic        err;
		int          polls;
		polls = 0;
		apb_read(REG_STATUS, rd, err);
		while (rd !== exp && polls < 40) begin
			apb_read(REG_STATUS, rd, err);
			polls++;
		end
		if (rd !== exp) begin
			errors++;
			$display("REG_STATUS never reached 0x%02h for %s, last read 0x%02h", exp, what, rd);
		end
		repeat (16) @(posedge CLK);
		apb_read(REG_STATUS, rd, err);
		compare_value("REG_STATUS", rd, exp);
		compare_value("pslverr", err, 32'd0);
	endtask

	task automatic drive_line(input logic [7:0] pattern);
		@(negedge CLK);
		loopback    = 1'b0;
		drv_pattern = pattern;
	endtask

	task automatic finish_test(input string name, input int start_errs);
		tests_run++;
		$display("test %-16s %0d errors", name, errors - start_errs);
	endtask

	initial begin
		int          start;
		logic [31:0] rd;
		logic [31:0] ctrl_before;
		logic        err;
		logic [1:0]  c;
		logic [7:0]  bad_addr;
		CLK          = 1'b0;
		MODULE_RST   = 1'b1;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = 8'd0;
		pwdata       = 32'd0;
		status_in    = 1'b0;
		loopback     = 1'b1;
		drv_pattern  = 8'h00;
		drv_shift    = 8'h00;
		drv_cnt      = 3'd0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		void'($urandom(46446));
		repeat (5) @(posedge CLK);
		#1;
		MODULE_RST   = 1'b0;
		// the all-zero window after reset counts as one idle entry.
		exp_idle_cnt = 1;
		last_cond    = COND_IDLE;

		start = errors;
		wait_flags(32'h10, "reset");
		apb_read(REG_CTRL, rd, err);
		compare_value("REG_CTRL", rd, 32'd0);
		compare_value("pslverr", err, 32'd0);
		@(negedge CLK);
		compare_value("status_out", status_out, 32'd0);
		finish_test("reset_state", start);

		start = errors;
		for (int i = 0; i < 20; i++) begin
			c = 2'($urandom % 4);
			apb_write(REG_CTRL, {29'd0, 1'b1, c}, err);
			compare_value("pslverr", err, 32'd0);
			apb_read(REG_CTRL, rd, err);
			compare_value("REG_CTRL", rd, {29'd0, 1'b1, c});
			note_cond(c);
			wait_flags(flags_for(c), "loopback");
		end
		finish_test("loopback", start);

		start = errors;
		apb_read(REG_IDLE_CNT, rd, err);
		compare_value("REG_IDLE_CNT", rd, exp_idle_cnt);
		apb_write(REG_IDLE_CNT, 32'hFFFF_FFFF, err);
		compare_value("pslverr", err, 32'd0);
		apb_read(REG_IDLE_CNT, rd, err);
		compare_value("REG_IDLE_CNT", rd, 32'd0);
		finish_test("idle_count", start);

		start = errors;
		for (int i = 0; i < 6; i++) begin
			c = 2'($urandom % 4);
			drive_line(rotate_left(code_for(c), $urandom % 8));
			wait_flags(flags_for(c), "rotated code");
		end
		finish_test("rotated_codes", start);

		// B4 has no rotation inside the code set.
		start = errors;
		drive_line(8'h33);
		wait_flags(32'h04, "training done");
		drive_line(8'hB4);
		wait_flags(32'h0C, "status error");
		drive_line(8'h33);
		wait_flags(32'h04, "error recovery");
		finish_test("status_error", start);

		start = errors;
		bad_addr = 8'(($urandom % 240) + 16);
		apb_read(REG_CTRL, ctrl_before, err);
		apb_write(bad_addr, $urandom, err);
		compare_value("pslverr", err, 32'd1);
		apb_read(bad_addr, rd, err);
		compare_value("pslverr", err, 32'd1);
		apb_read(REG_CTRL, rd, err);
		compare_value("REG_CTRL", rd, ctrl_before);
		compare_value("pslverr", err, 32'd0);
		finish_test("bus_errors", start);

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
